/* lsu_config.svh */
// Load-store unit configuration
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// ==============================
// Widths and sizes
// ==============================
`define LSU_XLEN        32
`define LSU_DM_BYTES    2048
`define LSU_DM_AW       11

// Upper address halves of the I/O regions
`define LSU_OUT_BASE_HI 16'h1000
`define LSU_IN_BASE_HI  16'h1001

// Output device codes, address bits 15 to 12
`define LSU_DEV_LEDR    4'h0
`define LSU_DEV_LEDG    4'h1
`define LSU_DEV_HEX03   4'h2
`define LSU_DEV_HEX47   4'h3

// ==============================
// Access codes, {store, funct3}
// ==============================
`define LSU_OP_LB       4'b0000
`define LSU_OP_LH       4'b0001
`define LSU_OP_LW       4'b0010
`define LSU_OP_LBU      4'b0100
`define LSU_OP_LHU      4'b0101
`define LSU_OP_SB       4'b1000
`define LSU_OP_SH       4'b1001
`define LSU_OP_SW       4'b1010

`endif

/* lsu_pkg.sv */
// Load-store unit types
`include "lsu_config.svh"

package lsu_pkg;

	// ==============================
	// Vector types
	// ==============================

	// Byte address, one word
	typedef logic [`LSU_XLEN-1:0] lsu_addr_t;

	// Store or load data word
	typedef logic [`LSU_XLEN-1:0] lsu_data_t;

	// Memory cell and hex digit
	typedef logic [7:0] lsu_byte_t;

	// Access code {store, funct3}
	typedef logic [3:0] lsu_bmask_t;

	// Data memory byte index
	typedef logic [`LSU_DM_AW-1:0] lsu_dm_idx_t;

	// Byte lane within a word
	typedef logic [1:0] lsu_lane_t;

	// Bytes written by a store code
	// Zero for loads and unknown codes
	function automatic logic [2:0] lsu_st_bytes(input lsu_bmask_t code);
		case (code)
			`LSU_OP_SB: return 3'd1;
			`LSU_OP_SH: return 3'd2;
			`LSU_OP_SW: return 3'd4;
			default:    return 3'd0;
		endcase
	endfunction

endpackage

/* lsu_bus_if.sv */
// Load-store internal bus
`timescale 1ns/1ps

interface lsu_bus_if
	import lsu_pkg::*;
();

	// Store bus, driven from the top ports
	lsu_addr_t  addr;
	lsu_data_t  wdata;
	logic       wren;
	lsu_bmask_t bmask;

	// Region selects from the decoder
	logic       dm_sel;
	logic       out_sel;
	logic       in_sel;

	// ==============================
	// Modports
	// ==============================

	// Address in, selects out
	modport decode (
		input  addr,
		output dm_sel,
		output out_sel,
		output in_sel
	);

	// Data memory side
	modport dm (input addr, input wdata, input wren, input bmask, input dm_sel);

	// Output register side
	modport outregs (input addr, input wdata, input wren, input bmask, input out_sel);

	// Bus master
	modport top (output addr, output wdata, output wren, output bmask);

endinterface

/* lsu_region_decode.sv */
// Region decode and load select
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_region_decode
	import lsu_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst,
	lsu_bus_if.decode bus,
	input  lsu_data_t i_io_sw,
	input  lsu_data_t i_dm_rdata,
	output lsu_data_t o_ld_data
);

	// Upper half of the address
	logic [15:0] addr_hi;

	// Switches sampled one cycle back
	lsu_data_t sw_q;

	assign addr_hi = bus.addr[31:16];

	// ==============================
	// Region selects
	// ==============================

	// Data memory 0x0000_0000 to 0x0000_07FF
	assign bus.dm_sel = (bus.addr[`LSU_XLEN-1:`LSU_DM_AW] == '0);

	// Output devices 0x1000_0000 to 0x1000_7FFF
	// Unused device codes are filtered in the register block
	assign bus.out_sel = (addr_hi == `LSU_OUT_BASE_HI) && !bus.addr[15];

	// Switches 0x1001_0000 to 0x1001_0FFF
	assign bus.in_sel = (addr_hi == `LSU_IN_BASE_HI) && (bus.addr[15:12] == 4'h0);

	// ==============================
	// Switch sampling
	// ==============================

	// Free-running sample every edge
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			sw_q <= '0;
		end else begin
			sw_q <= i_io_sw;
		end
	end

	// ==============================
	// Load result
	// ==============================

	always_comb begin
		// Reserved space reads as zero
		o_ld_data = '0;
		if (bus.dm_sel) begin
			o_ld_data = i_dm_rdata;
		end else if (bus.in_sel) begin
			// Only the switches live in the input region
			o_ld_data = sw_q;
		end
	end

endmodule

/* lsu_data_mem.sv */
// Byte-addressed data memory
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_data_mem
	import lsu_pkg::*;
(
	input  logic      i_clk,
	lsu_bus_if.dm     bus,
	output lsu_data_t o_rdata
);

	// 2 KiB of byte cells
	lsu_byte_t mem [`LSU_DM_BYTES];

	// First byte index from the low address bits
	lsu_dm_idx_t base_idx;

	// Consecutive byte indices, wrapping
	lsu_dm_idx_t byte_idx [4];

	// Bytes seen at the four indices
	lsu_byte_t rd_byte [4];

	// Store length and bounds check
	logic [2:0]  st_len;
	logic [11:0] st_last;
	logic        st_fits;
	logic        wr_en;

	assign base_idx = bus.addr[`LSU_DM_AW-1:0];

	always_comb begin
		for (int b = 0; b < 4; b++) begin
			byte_idx[b] = base_idx + lsu_dm_idx_t'(b);
		end
	end

	// ==============================
	// Store path
	// ==============================

	assign st_len = lsu_st_bytes(bus.bmask);

	// Index of the last byte touched by the store
	assign st_last = {1'b0, base_idx} + {9'd0, st_len} - 12'd1;

	// Stores running off the end are dropped whole
	assign st_fits = (st_len != 3'd0) && (st_last < 12'(`LSU_DM_BYTES));

	assign wr_en = bus.wren && bus.dm_sel && st_fits;

	// LSB goes to the lowest address
	always_ff @(posedge i_clk) begin
		if (wr_en) begin
			for (int b = 0; b < 4; b++) begin
				if (b < int'(st_len)) begin
					mem[byte_idx[b]] <= bus.wdata[8*b +: 8];
				end
			end
		end
	end

	// ==============================
	// Load path
	// ==============================

	always_comb begin
		for (int b = 0; b < 4; b++) begin
			rd_byte[b] = mem[byte_idx[b]];
		end
	end

	// Extension by access code
	always_comb begin
		case (bus.bmask)
			`LSU_OP_LB: begin
				o_rdata = {{24{rd_byte[0][7]}}, rd_byte[0]};
			end
			`LSU_OP_LH: begin
				// Sign from the upper byte of the half
				o_rdata = {{16{rd_byte[1][7]}}, rd_byte[1], rd_byte[0]};
			end
			`LSU_OP_LW: begin
				o_rdata = {rd_byte[3], rd_byte[2], rd_byte[1], rd_byte[0]};
			end
			`LSU_OP_LBU: begin
				o_rdata = {24'h0, rd_byte[0]};
			end
			`LSU_OP_LHU: begin
				o_rdata = {16'h0, rd_byte[1], rd_byte[0]};
			end
			default: begin
				// Store and unknown codes
				o_rdata = '0;
			end
		endcase
	end

endmodule

/* lsu_io_out_regs.sv */
// LED and seven-segment output registers
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_io_out_regs
	import lsu_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_rst,
	lsu_bus_if.outregs bus,
	output lsu_data_t  o_ledr,
	output lsu_data_t  o_ledg,
	output lsu_byte_t  o_hex_0,
	output lsu_byte_t  o_hex_1,
	output lsu_byte_t  o_hex_2,
	output lsu_byte_t  o_hex_3,
	output lsu_byte_t  o_hex_4,
	output lsu_byte_t  o_hex_5,
	output lsu_byte_t  o_hex_6,
	output lsu_byte_t  o_hex_7
);

	// Device code and lane from the address
	logic [3:0] dev;
	lsu_lane_t  lane;
	lsu_lane_t  lane_idx [4];
	logic [2:0] st_len;

	// Write strobes per device
	logic       wr_ledr;
	logic       wr_ledg;
	logic       wr_hex;
	logic       hex_bank;

	// Register storage, two banks of four digits
	lsu_data_t  ledr_q;
	lsu_data_t  ledg_q;
	lsu_byte_t  hex_q [2][4];

	assign dev  = bus.addr[15:12];
	assign lane = bus.addr[1:0];

	// Lanes wrap inside the bank
	always_comb begin
		for (int b = 0; b < 4; b++) begin
			lane_idx[b] = lane + lsu_lane_t'(b);
		end
	end

	assign st_len = lsu_st_bytes(bus.bmask);

	// ==============================
	// Device decode
	// ==============================
	assign wr_ledr  = bus.wren && bus.out_sel && (dev == `LSU_DEV_LEDR);
	assign wr_ledg  = bus.wren && bus.out_sel && (dev == `LSU_DEV_LEDG);
	assign wr_hex   = bus.wren && bus.out_sel &&
	                  ((dev == `LSU_DEV_HEX03) || (dev == `LSU_DEV_HEX47));
	assign hex_bank = (dev == `LSU_DEV_HEX47);

	// ==============================
	// Register writes
	// ==============================
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			ledr_q <= '0;
			ledg_q <= '0;
			hex_q  <= '{default: '0};
		end else begin
			// LEDs take the full word whatever the code
			if (wr_ledr) ledr_q <= bus.wdata;
			if (wr_ledg) ledg_q <= bus.wdata;
			// Byte lanes upward from the addressed digit
			if (wr_hex) begin
				for (int b = 0; b < 4; b++) begin
					if (b < int'(st_len)) begin
						hex_q[hex_bank][lane_idx[b]] <= bus.wdata[8*b +: 8];
					end
				end
			end
		end
	end

	assign o_ledr  = ledr_q;
	assign o_ledg  = ledg_q;
	assign o_hex_0 = hex_q[0][0];
	assign o_hex_1 = hex_q[0][1];
	assign o_hex_2 = hex_q[0][2];
	assign o_hex_3 = hex_q[0][3];
	assign o_hex_4 = hex_q[1][0];
	assign o_hex_5 = hex_q[1][1];
	assign o_hex_6 = hex_q[1][2];
	assign o_hex_7 = hex_q[1][3];

endmodule

/* lsu_top.sv */
// Load-store unit top level
`timescale 1ns/1ps

module lsu_top
	import lsu_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_rst,
	input  lsu_addr_t  i_lsu_addr,
	input  lsu_data_t  i_st_data,
	input  logic       i_lsu_wren,
	input  lsu_bmask_t i_bmask,
	input  lsu_data_t  i_io_sw,
	output lsu_data_t  o_ld_data,
	output lsu_data_t  o_io_ledr,
	output lsu_data_t  o_io_ledg,
	output lsu_byte_t  o_io_hex_0,
	output lsu_byte_t  o_io_hex_1,
	output lsu_byte_t  o_io_hex_2,
	output lsu_byte_t  o_io_hex_3,
	output lsu_byte_t  o_io_hex_4,
	output lsu_byte_t  o_io_hex_5,
	output lsu_byte_t  o_io_hex_6,
	output lsu_byte_t  o_io_hex_7
);

	// Memory read word into the load mux
	lsu_data_t dm_rdata;

	// ==============================
	// Internal bus
	// ==============================
	lsu_bus_if bus ();

	assign bus.addr  = i_lsu_addr;
	assign bus.wdata = i_st_data;
	assign bus.wren  = i_lsu_wren;
	assign bus.bmask = i_bmask;

	// Selects, switches and load result
	lsu_region_decode decode_i (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.bus        (bus.decode),
		.i_io_sw    (i_io_sw),
		.i_dm_rdata (dm_rdata),
		.o_ld_data  (o_ld_data)
	);

	// 2 KiB data memory
	lsu_data_mem dmem_i (
		.i_clk   (i_clk),
		.bus     (bus.dm),
		.o_rdata (dm_rdata)
	);

	// Output registers on the same store bus
	lsu_io_out_regs outregs_i (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.bus     (bus.outregs),
		.o_ledr  (o_io_ledr),
		.o_ledg  (o_io_ledg),
		.o_hex_0 (o_io_hex_0),
		.o_hex_1 (o_io_hex_1),
		.o_hex_2 (o_io_hex_2),
		.o_hex_3 (o_io_hex_3),
		.o_hex_4 (o_io_hex_4),
		.o_hex_5 (o_io_hex_5),
		.o_hex_6 (o_io_hex_6),
		.o_hex_7 (o_io_hex_7)
	);

endmodule

/* lsu_sva.sv */
// Load-store unit assertions
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_sva
	import lsu_pkg::*;
(
	input logic        i_clk,
	input logic        i_rst,
	input lsu_addr_t   i_addr,
	input logic        i_wren,
	input logic        i_dm_sel,
	input logic        i_out_sel,
	input logic        i_in_sel,
	input lsu_data_t   i_ld_data,
	input lsu_data_t   i_ledr,
	input lsu_data_t   i_ledg,
	input logic [63:0] i_hex
);

	// Address outside all three regions
	logic reserved;

	// Failed property count
	int fail_count = 0;

	assign reserved = (i_addr[`LSU_XLEN-1:`LSU_DM_AW] != '0) &&
	                  !((i_addr[31:16] == `LSU_OUT_BASE_HI) && !i_addr[15]) &&
	                  !((i_addr[31:16] == `LSU_IN_BASE_HI) && (i_addr[15:12] == 4'h0));

	// ==============================
	// Properties
	// ==============================

	// Regions never overlap
	one_region: assert property (@(posedge i_clk) disable iff (!i_rst)
		$onehot0({i_dm_sel, i_out_sel, i_in_sel}))
		else begin
			$error("more than one region select active");
			fail_count++;
		end

	// Reserved space loads as zero
	reserved_zero: assert property (@(posedge i_clk) disable iff (!i_rst)
		reserved |-> (i_ld_data == '0))
		else begin
			$error("nonzero load data at a reserved address");
			fail_count++;
		end

	// First cycle out of reset
	reset_clear: assert property (@(posedge i_clk)
		$rose(i_rst) |-> ((i_ledr == '0) && (i_ledg == '0) && (i_hex == '0)))
		else begin
			$error("output register not cleared by reset");
			fail_count++;
		end

	// LEDs hold without a store
	led_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
		!i_wren |=> ($stable(i_ledr) && $stable(i_ledg)))
		else begin
			$error("LED output changed without a store");
			fail_count++;
		end

endmodule

bind lsu_top lsu_sva sva_i (
	.i_clk     (i_clk),
	.i_rst     (i_rst),
	.i_addr    (i_lsu_addr),
	.i_wren    (i_lsu_wren),
	.i_dm_sel  (bus.dm_sel),
	.i_out_sel (bus.out_sel),
	.i_in_sel  (bus.in_sel),
	.i_ld_data (o_ld_data),
	.i_ledr    (o_io_ledr),
	.i_ledg    (o_io_ledg),
	.i_hex     ({o_io_hex_7, o_io_hex_6, o_io_hex_5, o_io_hex_4,
	             o_io_hex_3, o_io_hex_2, o_io_hex_1, o_io_hex_0})
);

/* lsu_tb_clkgen.sv */
// Testbench clock and reset
`timescale 1ns/1ps

module lsu_tb_clkgen (
	output logic o_clk,
	output logic o_rst
);

	// Half of the 20 ns period
	localparam int HALF_PERIOD = 10;

	initial begin
		o_clk = 1'b0;
		forever #HALF_PERIOD o_clk = ~o_clk;
	end

	// Reset held low for the first 16 cycles
	initial begin
		o_rst = 1'b0;
		repeat (16) @(posedge o_clk);
		#2;
		o_rst = 1'b1;
	end

endmodule

/* lsu_tb.sv */
// Load-store unit testbench
`timescale 1ns/1ps

module lsu_tb
	import lsu_pkg::*;
();

	// Eight hex fields per golden vector
	localparam int FIELDS    = 8;
	localparam int MAX_VECS  = 64;
	localparam int RST_LIMIT = 40;
	localparam int END_TEST  = 32'hff;

	logic clk;
	logic rst;

	// DUT inputs
	lsu_addr_t  lsu_addr;
	lsu_data_t  st_data;
	logic       lsu_wren;
	lsu_bmask_t bmask;
	lsu_data_t  io_sw;

	// DUT outputs
	lsu_data_t  ld_data;
	lsu_data_t  io_ledr;
	lsu_data_t  io_ledg;
	lsu_byte_t  hex_0;
	lsu_byte_t  hex_1;
	lsu_byte_t  hex_2;
	lsu_byte_t  hex_3;
	lsu_byte_t  hex_4;
	lsu_byte_t  hex_5;
	lsu_byte_t  hex_6;
	lsu_byte_t  hex_7;

	// Golden vectors in one flat array
	logic [31:0] golden [FIELDS*MAX_VECS];

	// Tallies
	int total_checks;
	int total_errors;
	int test_checks;
	int test_errors;
	int cur_test;
	bit aborted;

	lsu_tb_clkgen clkgen_i (.o_clk(clk), .o_rst(rst));

	lsu_top dut_i (
		.i_clk      (clk),
		.i_rst      (rst),
		.i_lsu_addr (lsu_addr),
		.i_st_data  (st_data),
		.i_lsu_wren (lsu_wren),
		.i_bmask    (bmask),
		.i_io_sw    (io_sw),
		.o_ld_data  (ld_data),
		.o_io_ledr  (io_ledr),
		.o_io_ledg  (io_ledg),
		.o_io_hex_0 (hex_0),
		.o_io_hex_1 (hex_1),
		.o_io_hex_2 (hex_2),
		.o_io_hex_3 (hex_3),
		.o_io_hex_4 (hex_4),
		.o_io_hex_5 (hex_5),
		.o_io_hex_6 (hex_6),
		.o_io_hex_7 (hex_7)
	);

	// ==============================
	// Helpers
	// ==============================

	// Output picked by the check column
	// Digits packed low to high
	function automatic lsu_data_t observed(input logic [3:0] sel);
		case (sel)
			4'd1:    return ld_data;
			4'd2:    return io_ledr;
			4'd3:    return io_ledg;
			4'd4:    return {hex_3, hex_2, hex_1, hex_0};
			4'd5:    return {hex_7, hex_6, hex_5, hex_4};
			default: return '0;
		endcase
	endfunction

	function automatic string port_name(input logic [3:0] sel);
		case (sel)
			4'd1:    return "o_ld_data";
			4'd2:    return "o_io_ledr";
			4'd3:    return "o_io_ledg";
			4'd4:    return "o_io_hex_3..0";
			default: return "o_io_hex_7..4";
		endcase
	endfunction

	// Apply one vector to the DUT inputs
	task automatic drive_vector(input int base);
		lsu_addr = golden[base+1];
		bmask    = golden[base+2][3:0];
		lsu_wren = golden[base+3][0];
		st_data  = golden[base+4];
		io_sw    = golden[base+5];
	endtask

	task automatic check_output(input logic [3:0] sel, input lsu_data_t exp);
		lsu_data_t got;
		got = observed(sel);
		total_checks++;
		test_checks++;
		assert (got === exp) else begin
			$display("** Error at %0t ns: test %0d %s expected %h, got %h",
			         $time, cur_test, port_name(sel), exp, got);
			total_errors++;
			test_errors++;
		end
	endtask

	task automatic report_test();
		if (test_errors == 0) begin
			$display("Test %0d: %0d checks passed", cur_test, test_checks);
		end else begin
			$display("Test %0d: %0d of %0d checks wrong", cur_test, test_errors, test_checks);
		end
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		int wait_cycles;
		int idx;
		int base;
		bit at_end;
		lsu_addr     = '0;
		st_data      = '0;
		lsu_wren     = 1'b0;
		bmask        = '0;
		io_sw        = '0;
		total_checks = 0;
		total_errors = 0;
		test_checks  = 0;
		test_errors  = 0;
		cur_test     = -1;
		aborted      = 1'b0;
		at_end       = 1'b0;
		$readmemh("lsu_golden.txt", golden);

		// Wait for reset release
		wait_cycles = 0;
		while (rst !== 1'b1 && wait_cycles < RST_LIMIT) begin
			@(posedge clk);
			wait_cycles++;
		end
		if (rst !== 1'b1) begin
			$display("Reset was never released, run stopped");
			aborted = 1'b1;
		end

		// One vector per cycle
		// Checked at the falling edge
		idx = 0;
		while (!aborted && !at_end && idx < MAX_VECS) begin
			base = idx * FIELDS;
			if (golden[base] === END_TEST) begin
				at_end = 1'b1;
			end else if ($isunknown(golden[base])) begin
				$display("Golden file ends at vector %0d without an end marker", idx);
				aborted = 1'b1;
			end else begin
				if (golden[base] != cur_test) begin
					if (cur_test >= 0) report_test();
					cur_test    = golden[base];
					test_checks = 0;
					test_errors = 0;
				end
				@(posedge clk);
				#2;
				drive_vector(base);
				@(negedge clk);
				if (golden[base+6][3:0] != 4'd0) begin
					check_output(golden[base+6][3:0], golden[base+7]);
				end
				idx++;
			end
		end
		if (cur_test >= 0) report_test();
		if (!aborted && !at_end) begin
			$display("Timed out before the end of the golden file");
			aborted = 1'b1;
		end

		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
		         total_checks, total_errors, dut_i.sva_i.fail_count);
		if (!aborted && total_errors == 0 && total_checks > 0 &&
		    dut_i.sva_i.fail_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* lsu_golden.txt */
// test addr code wren wdata sw chk exp, all hex, one vector per cycle
// chk 0 none, 1 load data, 2 ledr, 3 ledg, 4 hex 3..0, 5 hex 7..4; test ff ends
01 00000000 a 1 12345678 00000000 0 00000000
01 00000100 a 1 deadbeef 00000000 0 00000000
01 000007fc a 1 cafef00d 00000000 0 00000000
01 00000000 2 0 00000000 00000000 1 12345678
01 00000100 2 0 00000000 00000000 1 deadbeef
01 000007fc 2 0 00000000 00000000 1 cafef00d
02 00000010 a 1 00000000 00000000 0 00000000
02 00000011 8 1 00000085 00000000 0 00000000
02 00000012 9 1 0000f00c 00000000 0 00000000
02 00000010 2 0 00000000 00000000 1 f00c8500
02 00000011 0 0 00000000 00000000 1 ffffff85
02 00000011 4 0 00000000 00000000 1 00000085
02 00000012 1 0 00000000 00000000 1 fffff00c
02 00000012 5 0 00000000 00000000 1 0000f00c
02 00000010 1 0 00000000 00000000 1 ffff8500
02 000007ff 9 1 00001234 00000000 0 00000000
02 000007ff 4 0 00000000 00000000 1 000000ca
02 000007fc 2 0 00000000 00000000 1 cafef00d
03 10000000 a 1 a5a5a5a5 00000000 0 00000000
03 10001000 8 1 11223344 00000000 2 a5a5a5a5
03 10004000 a 1 ffffffff 00000000 3 11223344
03 00000000 2 0 00000000 00000000 2 a5a5a5a5
03 00000000 2 0 00000000 00000000 3 11223344
03 00000000 2 0 00000000 00000000 4 00000000
03 00000000 2 0 00000000 00000000 5 00000000
04 10002001 8 1 0000007e 00000000 0 00000000
04 10003002 a 1 44332211 00000000 4 00007e00
04 10002003 9 1 0000bbaa 00000000 5 22114433
04 00000000 2 0 00000000 00000000 4 aa007ebb
04 00000000 2 0 00000000 00000000 5 22114433
05 10010000 2 0 00000000 0000abcd 1 00000000
05 10010000 2 0 00000000 0000abcd 1 0000abcd
05 10010004 2 0 00000000 12345678 1 0000abcd
05 10010008 2 0 00000000 12345678 1 12345678
05 10011000 2 0 00000000 12345678 1 00000000
05 00000800 a 1 ffffffff 12345678 1 00000000
05 10008000 a 1 ffffffff 12345678 1 00000000
05 20000000 a 1 ffffffff 12345678 1 00000000
05 00000000 2 0 00000000 12345678 1 12345678
05 00000000 2 0 00000000 12345678 2 a5a5a5a5
05 00000000 2 0 00000000 12345678 3 11223344
05 00000000 2 0 00000000 12345678 4 aa007ebb
05 00000000 2 0 00000000 12345678 5 22114433
ff 00000000 0 0 00000000 00000000 0 00000000

/* src.f */
+incdir+.
lsu_pkg.sv
lsu_bus_if.sv
lsu_region_decode.sv
lsu_data_mem.sv
lsu_io_out_regs.sv
lsu_top.sv
lsu_sva.sv
lsu_tb_clkgen.sv
lsu_tb.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - include_dirs:
      - .
    files:
      - lsu_pkg.sv
      - lsu_bus_if.sv
      - lsu_region_decode.sv
      - lsu_data_mem.sv
      - lsu_io_out_regs.sv
      - lsu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - lsu_sva.sv
      - lsu_tb_clkgen.sv
      - lsu_tb.sv
